// ==== logic/erx_macros.svh ====
// sizing of the receive path, shared by the package, the RTL and the testbench
// ERX_SER_RATIO is kept a power of two so the bit counter wraps on its own
// ERX_GPIO_W is tied to the lane count: low data byte plus one frame bit

`ifndef ERX_MACROS_SVH
`define ERX_MACROS_SVH

// ############################
// link geometry
// ############################
`define ERX_LANES      8                 // data lanes, frame lane not counted
`define ERX_SER_RATIO  8                 // serial bits per lane per word

// gpio capture width, one bit per data lane plus frame bit 0
`define ERX_GPIO_W     (`ERX_LANES + 1)

`endif

// ==== logic/erx_pkg.sv ====
// vector types for the receive path, shared by RTL and testbench
// widths come from erx_macros.svh, so change them there and not here

`include "erx_macros.svh"

package erx_pkg;

   // ############################
   // lane level
   // ############################
   // one deserialized byte, first bit received in the msb
   typedef logic [`ERX_SER_RATIO-1:0] lane_byte_t;

   // position of the current bit inside a word
   typedef logic [$clog2(`ERX_SER_RATIO)-1:0] bit_cnt_t;

   // ############################
   // word level
   // ############################
   // packed data word, lane i bit k sits at bit (8k + i)
   typedef logic [`ERX_LANES*`ERX_SER_RATIO-1:0] rx_word_t;

   typedef logic [`ERX_SER_RATIO-1:0] rx_frame_t;   // frame lane byte

   // gpio capture, {frame bit 0, data bits 7..0}
   typedef logic [`ERX_GPIO_W-1:0] gpio_in_t;

endpackage

// ==== logic/erx_ctrl_sync.sv ====
// control side of the receiver, all on rxlclk_p
// enable and gpio mode are async inputs and pass through two flops each
// a low ecfg_rx_enable clears the enable sync at once, so lanes drop immediately
// wait outputs are combinational, no flop between gpio_wait and the pins

`include "erx_macros.svh"

module erx_ctrl_sync
(
   input  logic       rxlclk_p,
   input  logic       rxreset,
   input  logic       ecfg_rx_enable,
   input  logic       ecfg_rx_gpio_mode,
   input  logic [1:0] gpio_wait,          // [0] wr wait, [1] rd wait in gpio mode
   input  logic       rx_wr_wait,
   input  logic       rx_rd_wait,
   output logic       lane_rst,
   output logic       gpio_mode,
   output logic       word_tick,
   output logic       rx_wr_wait_out,
   output logic       rx_rd_wait_out
);

   import erx_pkg::*;

   logic       enb_clr;                   // async clear of the enable sync
   logic [1:0] rx_enb_sync;               // [1] first stage, [0] second stage
   logic [1:0] gpio_sync;
   logic       rx_enb;
   bit_cnt_t   bit_cnt;

   // ############################
   // synchronizers
   // ############################
   assign enb_clr = rxreset | ~ecfg_rx_enable;

   // shifts a one in, rx_enb rises on the second edge after enable
   always_ff @(posedge rxlclk_p or posedge enb_clr)
   begin
      if (enb_clr)
         rx_enb_sync <= '0;
      else
         rx_enb_sync <= {1'b1, rx_enb_sync[1]};
   end

   assign rx_enb   = rx_enb_sync[0];
   assign lane_rst = ~rx_enb;             // holds lanes and packer while disabled

   always_ff @(posedge rxlclk_p or posedge rxreset)
   begin
      if (rxreset)
         gpio_sync <= '0;
      else
         gpio_sync <= {ecfg_rx_gpio_mode, gpio_sync[1]};   // two edges to take effect
   end

   assign gpio_mode = gpio_sync[0];

   // ############################
   // word alignment
   // ############################
   // count starts at 0 with the first sampled bit after rx_enb rises,
   // so every restart of the enable realigns the words
   always_ff @(posedge rxlclk_p or posedge lane_rst)
   begin
      if (lane_rst)
         bit_cnt <= '0;
      else if (word_tick)
         bit_cnt <= '0;                   // wrap after the last bit
      else
         bit_cnt <= bit_cnt + 1'b1;
   end

   // high while the last bit of a word sits on the lanes
   assign word_tick = (bit_cnt == bit_cnt_t'(`ERX_SER_RATIO - 1));

   // wait mux, gpio mode forces the pins from the config register
   assign rx_wr_wait_out = gpio_mode ? gpio_wait[0] : rx_wr_wait;
   assign rx_rd_wait_out = gpio_mode ? gpio_wait[1] : rx_rd_wait;

   // lanes and packer rely on a steady word period once enabled
   a_tick_period : assert property (@(posedge rxlclk_p) disable iff (lane_rst)
      word_tick |-> ##1 (!word_tick) [*(`ERX_SER_RATIO - 1)] ##1 word_tick)
      else $error("word_tick period broken");

endmodule

// ==== logic/erx_lane_deser.sv ====
// one serial lane to one byte, one bit per rxlclk_p edge
// first bit received ends up in bit 7 of lane_byte
// lane_byte holds from one word_tick to the next

module erx_lane_deser
(
   input  logic               rxlclk_p,
   input  logic               lane_rst,       // async clear, like the serdes reset
   input  logic               word_tick,      // last bit of the word is on ser_in
   input  logic               ser_in,
   output erx_pkg::lane_byte_t lane_byte
);

   import erx_pkg::*;

   lane_byte_t shift_q;                       // newest bit in the lsb

   // ############################
   // shift and hold
   // ############################
   always_ff @(posedge rxlclk_p or posedge lane_rst)
   begin
      if (lane_rst)
         shift_q <= '0;
      else
         shift_q <= {shift_q[$bits(lane_byte_t)-2:0], ser_in};
   end

   // seven older bits plus the one arriving now make the byte
   always_ff @(posedge rxlclk_p or posedge lane_rst)
   begin
      if (lane_rst)
         lane_byte <= '0;
      else if (word_tick)
         lane_byte <= {shift_q[$bits(lane_byte_t)-2:0], ser_in};
   end

endmodule

// ==== logic/erx_word_pack.sv ====
// packs the lane bytes into the 64-bit data word and the frame word
// two register stages after the lane hold bytes, valid is a one-cycle strobe
// frame reads zero while disabled or in gpio mode, data still passes
// gpio_datain follows one edge after each valid word

`include "erx_macros.svh"

module erx_word_pack
(
   input  logic                rxlclk_p,
   input  logic                rxreset,
   input  logic                lane_rst,
   input  logic                word_tick,
   input  logic                gpio_mode,
   input  erx_pkg::lane_byte_t lane_bytes [`ERX_LANES],
   input  erx_pkg::lane_byte_t frame_byte,
   output erx_pkg::rx_word_t   rx_data,
   output erx_pkg::rx_frame_t  rx_frame,
   output logic                rx_word_valid,
   output erx_pkg::gpio_in_t   gpio_datain
);

   import erx_pkg::*;

   logic      pack_rst;                   // full reset or receiver disabled
   logic      tick_q1;                    // lane hold bytes fresh
   logic      tick_q2;                    // first stage fresh
   rx_word_t  pack_word;
   rx_frame_t frame_mask;
   rx_word_t  data_q1;
   rx_frame_t frame_q1;

   assign pack_rst = rxreset | lane_rst;

   // ############################
   // interleave and mask
   // ############################
   always_comb
   begin
      for (int k = 0; k < `ERX_SER_RATIO; k++)
      begin
         for (int i = 0; i < `ERX_LANES; i++)
            pack_word[k*`ERX_LANES + i] = lane_bytes[i][k];   // lane i bit k
      end
   end

   // masked like the reference, by enable and by gpio mode
   assign frame_mask = frame_byte & {`ERX_SER_RATIO{~lane_rst}}
                                  & {`ERX_SER_RATIO{~gpio_mode}};

   // ############################
   // register stages
   // ############################
   always_ff @(posedge rxlclk_p or posedge pack_rst)
   begin
      if (pack_rst)
      begin
         tick_q1       <= 1'b0;
         tick_q2       <= 1'b0;
         rx_word_valid <= 1'b0;
         data_q1       <= '0;
         frame_q1      <= '0;
         rx_data       <= '0;
         rx_frame      <= '0;
         gpio_datain   <= '0;
      end
      else
      begin
         tick_q1       <= word_tick;      // hold bytes load on the tick edge
         tick_q2       <= tick_q1;
         rx_word_valid <= tick_q2;        // one cycle, one per word
         if (tick_q1)
         begin
            data_q1  <= pack_word;
            frame_q1 <= frame_mask;
         end
         if (tick_q2)
         begin
            rx_data  <= data_q1;
            rx_frame <= frame_q1;
         end
         if (rx_word_valid)               // gpio sees the word one edge late
            gpio_datain <= {rx_frame[0], rx_data[`ERX_LANES-1:0]};
      end
   end

   // after lane reset a whole word has to pass the lanes and both stages
   a_no_early_valid : assert property (@(posedge rxlclk_p)
      $fell(lane_rst) |-> (!rx_word_valid) [*(`ERX_SER_RATIO + 2)])
      else $error("rx_word_valid before a full word after lane reset");

endmodule

// ==== logic/erx_io.sv ====
// receive side of the eight-lane link, single clock rxlclk_p
// one bit per lane per edge stands in for DDR capture, no bitslip
// words align to the first bit after the enable sync, no training pattern
// rx_word_valid strobes once every eight edges, there is no back-pressure

`include "erx_macros.svh"

module erx_io
(
   input  logic                   rxlclk_p,
   input  logic                   rxreset,
   input  logic [`ERX_LANES-1:0]  rx_data_in,     // one serial bit per lane
   input  logic                   rx_frame_in,
   input  logic                   rx_wr_wait,
   input  logic                   rx_rd_wait,
   input  logic                   ecfg_rx_enable,
   input  logic                   ecfg_rx_gpio_mode,
   input  logic [1:0]             gpio_wait,
   output erx_pkg::rx_word_t      rx_data,
   output erx_pkg::rx_frame_t     rx_frame,
   output logic                   rx_word_valid,
   output erx_pkg::gpio_in_t      gpio_datain,
   output logic                   rx_wr_wait_out,
   output logic                   rx_rd_wait_out
);

   import erx_pkg::*;

   logic                lane_rst;
   logic                gpio_mode;
   logic                word_tick;
   logic [`ERX_LANES:0] ser_bits;                 // frame lane on top
   lane_byte_t          data_bytes [`ERX_LANES];
   lane_byte_t          frame_byte;

   assign ser_bits = {rx_frame_in, rx_data_in};

   // ############################
   // control
   // ############################
   erx_ctrl_sync u_ctrl
   (
      .rxlclk_p          (rxlclk_p),
      .rxreset           (rxreset),
      .ecfg_rx_enable    (ecfg_rx_enable),
      .ecfg_rx_gpio_mode (ecfg_rx_gpio_mode),
      .gpio_wait         (gpio_wait),
      .rx_wr_wait        (rx_wr_wait),
      .rx_rd_wait        (rx_rd_wait),
      .lane_rst          (lane_rst),
      .gpio_mode         (gpio_mode),
      .word_tick         (word_tick),
      .rx_wr_wait_out    (rx_wr_wait_out),
      .rx_rd_wait_out    (rx_rd_wait_out)
   );

   // ############################
   // lanes, index ERX_LANES is the frame lane
   // ############################
   for (genvar i = 0; i <= `ERX_LANES; i++)
   begin : gen_lane
      lane_byte_t lane_q;

      erx_lane_deser u_deser
      (
         .rxlclk_p  (rxlclk_p),
         .lane_rst  (lane_rst),
         .word_tick (word_tick),
         .ser_in    (ser_bits[i]),
         .lane_byte (lane_q)
      );

      if (i < `ERX_LANES)
      begin : g_data
         assign data_bytes[i] = lane_q;
      end
      else
      begin : g_frame
         assign frame_byte = lane_q;
      end
   end

   erx_word_pack u_pack
   (
      .rxlclk_p      (rxlclk_p),
      .rxreset       (rxreset),
      .lane_rst      (lane_rst),
      .word_tick     (word_tick),
      .gpio_mode     (gpio_mode),
      .lane_bytes    (data_bytes),
      .frame_byte    (frame_byte),
      .rx_data       (rx_data),
      .rx_frame      (rx_frame),
      .rx_word_valid (rx_word_valid),
      .gpio_datain   (gpio_datain)
   );

endmodule

// ==== dv/erx_io_tb.sv ====
// testbench for erx_io, one clock, every input driven on the falling edge
// stimulus comes from a 16-bit lfsr, expected words are packed from the driven bits
// a word is due 2 + 8 + 2 edges after enable, then one every 8 edges

`include "erx_macros.svh"

module erx_io_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import erx_pkg::*;

   localparam int CLK_PERIOD       = 10;
   localparam int WORDS_PLAIN      = 80;            // gpio mode off
   localparam int WORDS_GPIO       = 60;            // frame masked, waits from gpio_wait
   localparam int WORDS_BACK       = 20;            // gpio mode off again
   localparam int WORDS_RESTART    = 40;            // after the mid-word disable
   localparam int NUM_WORDS        = WORDS_PLAIN + WORDS_GPIO + WORDS_BACK + WORDS_RESTART;
   localparam int WATCHDOG_NS      = NUM_WORDS * `ERX_SER_RATIO * CLK_PERIOD + 1000;
   localparam int FIRST_WORD_EDGES = 2 + `ERX_SER_RATIO + 2;   // sync, bits, two stages

   logic                  rxlclk_p;
   logic                  rxreset;
   logic [`ERX_LANES-1:0] rx_data_in;
   logic                  rx_frame_in;
   logic                  rx_wr_wait;
   logic                  rx_rd_wait;
   logic                  ecfg_rx_enable;
   logic                  ecfg_rx_gpio_mode;
   logic [1:0]            gpio_wait;
   rx_word_t              rx_data;
   rx_frame_t             rx_frame;
   logic                  rx_word_valid;
   gpio_in_t              gpio_datain;
   logic                  rx_wr_wait_out;
   logic                  rx_rd_wait_out;

   // ##############################
   // model state
   // ##############################
   logic [15:0] lfsr_state = 16'd44467;
   int          cyc = 0;                   // rising edges so far
   bit          tracking = 1'b0;           // bits go into words
   int          first_edge;                // edge that samples bit 0 of word 0
   int          enable_cyc;
   bit          await_first = 1'b0;
   int          words_pushed = 0;
   logic        gm_drive = 1'b0;           // gpio mode to drive next
   logic        gm_d1 = 1'b0;              // gpio mode sampled at the last edge
   logic        gm_d2 = 1'b0;              // gpio mode the DUT uses now
   lane_byte_t  acc [`ERX_LANES];
   lane_byte_t  acc_frame;
   rx_word_t    exp_data_q [$];
   rx_frame_t   exp_frame_q [$];
   int          due_q [$];                 // edge after which valid is high
   gpio_in_t    exp_gpio = '0;
   gpio_in_t    gpio_next = '0;
   int          gpio_due = -1;
   string       test_name = "reset";
   int          err_word = 0;
   int          err_frame = 0;
   int          err_gpio = 0;
   int          err_wait = 0;
   int          err_valid = 0;

   erx_io DUT
   (
      .rxlclk_p          (rxlclk_p),
      .rxreset           (rxreset),
      .rx_data_in        (rx_data_in),
      .rx_frame_in       (rx_frame_in),
      .rx_wr_wait        (rx_wr_wait),
      .rx_rd_wait        (rx_rd_wait),
      .ecfg_rx_enable    (ecfg_rx_enable),
      .ecfg_rx_gpio_mode (ecfg_rx_gpio_mode),
      .gpio_wait         (gpio_wait),
      .rx_data           (rx_data),
      .rx_frame          (rx_frame),
      .rx_word_valid     (rx_word_valid),
      .gpio_datain       (gpio_datain),
      .rx_wr_wait_out    (rx_wr_wait_out),
      .rx_rd_wait_out    (rx_rd_wait_out)
   );

   initial
   begin
      rxlclk_p = 1'b0;
      forever #(CLK_PERIOD / 2) rxlclk_p = ~rxlclk_p;
   end

   initial
   begin
      forever
      begin
         @(posedge rxlclk_p);
         cyc++;
      end
   end

   // fibonacci lfsr, taps 16 14 13 11, one step per bit
   function automatic logic next_rand_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   // ##############################
   // compare tasks
   // ##############################
   task automatic check_word(input string label, input rx_word_t exp_val,
                             input rx_word_t act_val);
      if (act_val !== exp_val)
      begin
         $display("error %s %s: expected %h, actual %h", test_name, label, exp_val, act_val);
         err_word++;
      end
   endtask

   task automatic check_frame(input string label, input rx_frame_t exp_val,
                              input rx_frame_t act_val);
      if (act_val !== exp_val)
      begin
         $display("error %s %s: expected %h, actual %h", test_name, label, exp_val, act_val);
         err_frame++;
      end
   endtask

   task automatic check_gpio(input string label, input gpio_in_t exp_val,
                             input gpio_in_t act_val);
      if (act_val !== exp_val)
      begin
         $display("error %s %s: expected %h, actual %h", test_name, label, exp_val, act_val);
         err_gpio++;
      end
   endtask

   task automatic check_wait(input string label, input logic exp_val, input logic act_val);
      if (act_val !== exp_val)
      begin
         $display("error %s %s: expected %b, actual %b", test_name, label, exp_val, act_val);
         err_wait++;
      end
   endtask

   task automatic check_valid(input string label, input logic exp_val, input logic act_val);
      if (act_val !== exp_val)
      begin
         $display("error %s %s: expected %b, actual %b", test_name, label, exp_val, act_val);
         err_valid++;
      end
   endtask

   // ##############################
   // one cycle: check, then drive
   // ##############################
   task automatic step_cycle();
      logic      exp_valid;
      int        j;
      rx_word_t  word;
      rx_frame_t frame;
      @(negedge rxlclk_p);
      gm_d2 = gm_d1;                       // gpio mode lags its input by two edges
      gm_d1 = ecfg_rx_gpio_mode;
      check_wait("wr wait", gm_d2 ? gpio_wait[0] : rx_wr_wait, rx_wr_wait_out);
      check_wait("rd wait", gm_d2 ? gpio_wait[1] : rx_rd_wait, rx_rd_wait_out);
      exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
      check_valid("word valid", exp_valid, rx_word_valid);
      if (await_first && rx_word_valid)
      begin
         await_first = 1'b0;
         if (cyc - enable_cyc != FIRST_WORD_EDGES)
         begin
            $display("first word after enable came %0d edges after it instead of %0d",
                     cyc - enable_cyc, FIRST_WORD_EDGES);
            err_valid++;
         end
      end
      if (exp_valid)
      begin
         check_word("data word", exp_data_q[0], rx_data);
         check_frame("frame word", exp_frame_q[0], rx_frame);
         gpio_next = {exp_frame_q[0][0], exp_data_q[0][`ERX_LANES-1:0]};
         gpio_due  = cyc + 1;              // captured one edge after valid
         void'(exp_data_q.pop_front());
         void'(exp_frame_q.pop_front());
         void'(due_q.pop_front());
      end
      if (gpio_due == cyc)
         exp_gpio = gpio_next;
      check_gpio("gpio capture", exp_gpio, gpio_datain);

      // new bits, sampled at edge cyc + 1
      for (int l = 0; l < `ERX_LANES; l++)
         rx_data_in[l] = next_rand_bit();
      rx_frame_in  = next_rand_bit();
      rx_wr_wait   = next_rand_bit();
      rx_rd_wait   = next_rand_bit();
      gpio_wait[0] = next_rand_bit();
      gpio_wait[1] = next_rand_bit();
      if (tracking && (cyc + 1 >= first_edge))
      begin
         j = cyc + 1 - first_edge;
         for (int l = 0; l < `ERX_LANES; l++)
            acc[l] = {acc[l][`ERX_SER_RATIO-2:0], rx_data_in[l]};   // first bit ends in msb
         acc_frame = {acc_frame[`ERX_SER_RATIO-2:0], rx_frame_in};
         if ((j % `ERX_SER_RATIO) == (`ERX_SER_RATIO - 1))
         begin
            for (int k = 0; k < `ERX_SER_RATIO; k++)
               for (int i = 0; i < `ERX_LANES; i++)
                  word[k*`ERX_LANES + i] = acc[i][k];
            // mask uses the gpio bit sampled one edge before the last bit
            frame = ecfg_rx_gpio_mode ? '0 : acc_frame;
            exp_data_q.push_back(word);
            exp_frame_q.push_back(frame);
            due_q.push_back(cyc + 3);
            words_pushed++;
         end
      end
      ecfg_rx_gpio_mode = gm_drive;
   endtask

   task automatic run_words(input int count);
      int target;
      target = words_pushed + count;
      while (words_pushed < target)
         step_cycle();
   endtask

   task automatic enable_rx();
      ecfg_rx_enable = 1'b1;
      tracking       = 1'b1;
      first_edge     = cyc + 3;            // two sync edges, then bit 0
      enable_cyc     = cyc;
      await_first    = 1'b1;
      for (int l = 0; l < `ERX_LANES; l++)
         acc[l] = '0;
      acc_frame = '0;
   endtask

   task automatic disable_rx();
      ecfg_rx_enable = 1'b0;               // clears the enable sync at once
      tracking       = 1'b0;
      exp_data_q.delete();
      exp_frame_q.delete();
      due_q.delete();
      exp_gpio = '0;
      gpio_due = -1;
      #1;
      check_valid("valid drops on disable", 1'b0, rx_word_valid);
      check_word("data clears on disable", '0, rx_data);
      check_gpio("gpio clears on disable", '0, gpio_datain);
   endtask

   // ##############################
   // sequence
   // ##############################
   initial
   begin : main
      int total;
      rxreset           = 1'b1;
      rx_data_in        = '0;
      rx_frame_in       = 1'b0;
      rx_wr_wait        = 1'b0;
      rx_rd_wait        = 1'b0;
      ecfg_rx_enable    = 1'b0;
      ecfg_rx_gpio_mode = 1'b0;
      gpio_wait         = 2'b00;
      repeat (2) @(posedge rxlclk_p);
      @(negedge rxlclk_p);
      rxreset = 1'b0;
      check_valid("valid after reset", 1'b0, rx_word_valid);
      check_word("data after reset", '0, rx_data);
      check_frame("frame after reset", '0, rx_frame);
      check_gpio("gpio after reset", '0, gpio_datain);

      test_name = "plain data";
      enable_rx();
      run_words(WORDS_PLAIN);
      test_name = "gpio mode";
      gm_drive  = 1'b1;
      run_words(WORDS_GPIO);
      test_name = "gpio mode off";
      gm_drive  = 1'b0;
      run_words(WORDS_BACK);

      // disable on the cycle the last word is valid, three bits into the next
      test_name = "disable";
      repeat (3) step_cycle();
      disable_rx();
      repeat (6) step_cycle();
      test_name = "restart";
      enable_rx();
      run_words(WORDS_RESTART);
      repeat (4) step_cycle();             // drain the last word and its gpio capture

      total = err_word + err_frame + err_gpio + err_wait + err_valid;
      $display("errors: word %0d, frame %0d, gpio %0d, wait %0d, valid %0d",
               err_word, err_frame, err_gpio, err_wait, err_valid);
      if (total == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // whole sequence is about NUM_WORDS words long
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+logic
logic/erx_pkg.sv
logic/erx_ctrl_sync.sv
logic/erx_lane_deser.sv
logic/erx_word_pack.sv
logic/erx_io.sv
dv/erx_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the erx_io testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module erx_io_tb \
   -Mdir "$BUILD_DIR" -o erx_io_sim \
   -f sources.f

"./$BUILD_DIR/erx_io_sim" | tee "$LOG_FILE"

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
   echo "simulation failed, see $LOG_FILE"
   exit 1
fi
echo "simulation finished without failures"
